//--- gat_pkg.sv
// Shared sizes, state and MAC opcode types, and the result type; imported by every core module
package gat_pkg;

  // ====================================================================
  // Size defaults
  // ====================================================================
  parameter int DATA_WIDTH        = 8;
  parameter int TOTAL_NODES       = 8;
  parameter int NUM_FEATURE_IN    = 16;
  parameter int NUM_FEATURE_OUT   = 4;
  parameter int H_NUM_SPARSE_DATA = 48;
  parameter int NEW_FEATURE_WIDTH = 32;

  // Packed H entry is {column, value}
  parameter int COL_IDX_WIDTH     = $clog2(NUM_FEATURE_IN);
  parameter int H_DATA_WIDTH      = DATA_WIDTH + COL_IDX_WIDTH;

  // A full row holds NUM_FEATURE_IN entries, so one extra bit
  parameter int ROW_LEN_WIDTH     = $clog2(NUM_FEATURE_IN) + 1;

  // ====================================================================
  // Memory address widths
  // ====================================================================
  parameter int H_DATA_ADDR_W      = $clog2(H_NUM_SPARSE_DATA);
  parameter int NODE_INFO_ADDR_W   = $clog2(TOTAL_NODES);
  parameter int WEIGHT_ADDR_W      = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT);
  parameter int NEW_FEATURE_ADDR_W = $clog2(TOTAL_NODES * NUM_FEATURE_OUT);

  // ====================================================================
  // Types
  // ====================================================================
  typedef logic signed [NEW_FEATURE_WIDTH-1:0] feat_t;

  typedef enum logic [3:0] {
    IDLE      = 4'd0,
    INFO_RD   = 4'd1,
    INFO_WAIT = 4'd2,
    NZ_RD     = 4'd3,
    NZ_WAIT   = 4'd4,
    W_ISSUE   = 4'd5,
    W_DRAIN   = 4'd6,
    WR_OUT    = 4'd7,
    DONE      = 4'd8
  } gat_state_e;

  typedef enum logic [1:0] {
    MAC_HOLD  = 2'd0,
    MAC_CLEAR = 2'd1,
    MAC_ACC   = 2'd2
  } mac_op_e;

endpackage

//--- gat_bram.sv
// Simple dual-port block memory for the core; write on port a, registered read on port b
`timescale 1ns/1ps

module gat_bram #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 64
)(
  input  logic                     clk,
  input  logic                     ena,
  input  logic                     wea,
  input  logic [$clog2(DEPTH)-1:0] addra,
  input  logic [WIDTH-1:0]         dina,
  input  logic [$clog2(DEPTH)-1:0] addrb,
  output logic [WIDTH-1:0]         doutb
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (ena && wea) begin
      mem[addra] <= dina;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    doutb <= mem[addrb];
  end

  // Host or core must never write past the end
  a_wr_in_range: assert property (@(posedge clk) (ena && wea) |-> (addra < DEPTH))
    else $error("gat_bram write address %0d out of range", addra);

endmodule

//--- gat_index_counter.sv
// Row, nonzero and lane counters stepped by the FSM, plus the row and nonzero debug tallies
`timescale 1ns/1ps

module gat_index_counter #(
  parameter int TOTAL_NODES       = gat_pkg::TOTAL_NODES,
  parameter int NUM_FEATURE_OUT   = gat_pkg::NUM_FEATURE_OUT,
  parameter int H_NUM_SPARSE_DATA = gat_pkg::H_NUM_SPARSE_DATA,
  parameter int ROW_LEN_WIDTH     = gat_pkg::ROW_LEN_WIDTH,
  parameter int H_DATA_ADDR_W     = gat_pkg::H_DATA_ADDR_W,
  parameter int NODE_INFO_ADDR_W  = gat_pkg::NODE_INFO_ADDR_W
)(
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               run_start,
  input  logic                               row_load,
  input  logic [ROW_LEN_WIDTH-1:0]           row_len,
  input  logic                               row_inc,
  input  logic                               nz_inc,
  input  logic                               lane_inc,
  input  logic                               lane_clr,
  output logic [NODE_INFO_ADDR_W-1:0]        row_idx,
  output logic [H_DATA_ADDR_W-1:0]           nz_ptr,
  output logic [$clog2(NUM_FEATURE_OUT)-1:0] lane,
  output logic                               row_last,
  output logic                               row_empty,
  output logic                               nz_last,
  output logic                               lane_last,
  output logic [31:0]                        rows_done,
  output logic [31:0]                        nz_done
);

  // Entries still to consume in the current row
  logic [ROW_LEN_WIDTH-1:0] remaining;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      row_idx   <= '0;
      nz_ptr    <= '0;
      remaining <= '0;
      lane      <= '0;
      rows_done <= '0;
      nz_done   <= '0;
    end else begin
      if (run_start) begin
        row_idx   <= '0;
        nz_ptr    <= '0;
        rows_done <= '0;
        nz_done   <= '0;
      end else begin
        if (row_inc) begin
          row_idx   <= row_idx + 1'b1;
          rows_done <= rows_done + 1'b1;
        end
        if (nz_inc) begin
          nz_ptr  <= nz_ptr + 1'b1;
          nz_done <= nz_done + 1'b1;
        end
      end
      // Rows are packed back to back, so only the count reloads
      if (row_load) begin
        remaining <= row_len;
      end else if (nz_inc) begin
        remaining <= remaining - 1'b1;
      end
      if (lane_clr) begin
        lane <= '0;
      end else if (lane_inc) begin
        lane <= lane + 1'b1;
      end
    end
  end

  assign row_last  = (row_idx == NODE_INFO_ADDR_W'(TOTAL_NODES - 1));
  assign row_empty = (remaining == '0);
  assign nz_last   = (remaining == ROW_LEN_WIDTH'(1));
  assign lane_last = (lane == $clog2(NUM_FEATURE_OUT)'(NUM_FEATURE_OUT - 1));

  // node_info totals larger than the H memory would run the pointer off the end
  a_nz_ptr_range: assert property (@(posedge clk) disable iff (!arst_n)
    nz_inc |-> (nz_ptr < H_NUM_SPARSE_DATA))
    else $error("nz_ptr %0d beyond H memory", nz_ptr);

endmodule

//--- gat_ctrl.sv
// Sequencing FSM for the core; drives reads, counter steps, MAC opcodes and feature writes
`timescale 1ns/1ps

module gat_ctrl (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                h_done,
  input  logic                info_done,
  input  logic                wgt_done,
  input  logic                row_last,
  input  logic                row_empty,
  input  logic                nz_last,
  input  logic                lane_last,
  output logic                info_rd,
  output logic                nz_rd,
  output logic                feat_we,
  output logic                run_start,
  output logic                row_load,
  output logic                row_inc,
  output logic                nz_inc,
  output logic                lane_inc,
  output logic                lane_clr,
  output gat_pkg::mac_op_e    mac_op,
  output gat_pkg::gat_state_e state,
  output logic                gat_ready
);

  import gat_pkg::*;

  gat_state_e state_nxt;
  logic       all_done;
  logic       lane_step;

  assign all_done = h_done && info_done && wgt_done;

  // ====================================================================
  // Next state
  // ====================================================================
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:      if (all_done) state_nxt = INFO_RD;
      INFO_RD:   state_nxt = INFO_WAIT;
      INFO_WAIT: state_nxt = W_DRAIN;
      // Also lets the row clear land before the first write-out
      W_DRAIN:   state_nxt = row_empty ? WR_OUT : NZ_RD;
      NZ_RD:     state_nxt = NZ_WAIT;
      NZ_WAIT:   state_nxt = W_ISSUE;
      W_ISSUE:   if (lane_last) state_nxt = W_DRAIN;
      WR_OUT:    if (lane_last) state_nxt = row_last ? DONE : INFO_RD;
      DONE:      if (!all_done) state_nxt = IDLE;
      default:   state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      gat_ready <= 1'b0;
    end else begin
      state     <= state_nxt;
      gat_ready <= (state_nxt == DONE);
    end
  end

  // ====================================================================
  // Strobes
  // ====================================================================
  assign lane_step = (state == W_ISSUE) || (state == WR_OUT);

  assign run_start = (state == IDLE) && all_done;
  assign info_rd   = (state == INFO_RD);
  assign row_load  = (state == INFO_WAIT);
  assign nz_rd     = (state == NZ_RD);
  assign nz_inc    = (state == W_ISSUE) && lane_last;
  assign feat_we   = (state == WR_OUT);
  assign row_inc   = (state == WR_OUT) && lane_last;
  assign lane_inc  = lane_step && !lane_last;
  assign lane_clr  = lane_step && lane_last;

  always_comb begin
    case (state)
      INFO_WAIT: mac_op = MAC_CLEAR;
      W_ISSUE:   mac_op = MAC_ACC;
      default:   mac_op = MAC_HOLD;
    endcase
  end

  a_ready_in_done: assert property (@(posedge clk) disable iff (!arst_n)
    gat_ready |-> (state == DONE));

  a_we_in_wr_out: assert property (@(posedge clk) disable iff (!arst_n)
    feat_we |-> (state == WR_OUT));

  // Last nonzero of a row goes straight to write-out after the drain
  a_last_nz_to_out: assert property (@(posedge clk) disable iff (!arst_n)
    (nz_inc && nz_last) |=> (state == W_DRAIN) ##1 (state == WR_OUT));

endmodule

//--- gat_spmv_mac.sv
// Per-lane signed multiply-accumulate bank; opcode, lane and value are delayed to meet weight data
`timescale 1ns/1ps

module gat_spmv_mac #(
  parameter int DATA_WIDTH      = gat_pkg::DATA_WIDTH,
  parameter int NUM_FEATURE_OUT = gat_pkg::NUM_FEATURE_OUT
)(
  input  logic                               clk,
  input  logic                               arst_n,
  input  gat_pkg::mac_op_e                   mac_op,
  input  logic [$clog2(NUM_FEATURE_OUT)-1:0] lane,
  input  logic signed [DATA_WIDTH-1:0]       h_value,
  input  logic signed [DATA_WIDTH-1:0]       w_value,
  input  logic [$clog2(NUM_FEATURE_OUT)-1:0] rd_lane,
  output gat_pkg::feat_t                     result
);

  import gat_pkg::*;

  localparam int LANE_W = $clog2(NUM_FEATURE_OUT);

  mac_op_e                       op_q;
  logic [LANE_W-1:0]             lane_q;
  logic signed [DATA_WIDTH-1:0]  value_q;
  logic signed [2*DATA_WIDTH-1:0] product;
  feat_t                         acc [NUM_FEATURE_OUT];

  // ====================================================================
  // Alignment stage
  // ====================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_q <= MAC_HOLD;
    end else begin
      op_q <= mac_op;
    end
  end

  always_ff @(posedge clk) begin
    lane_q  <= lane;
    value_q <= h_value;
  end

  // Full-width product, sign extended before the add
  assign product = value_q * w_value;

  // ====================================================================
  // Accumulators
  // ====================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
        acc[i] <= '0;
      end
    end else begin
      case (op_q)
        MAC_CLEAR: begin
          for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
            acc[i] <= '0;
          end
        end
        MAC_ACC: acc[lane_q] <= acc[lane_q] + feat_t'(product);
        default: ;
      endcase
    end
  end

  // Write-out view of one lane
  assign result = acc[rd_lane];

endmodule

//--- gat_top.sv
// Feature-transform core; ties the four memories, the counters, the FSM and the MAC bank together
`timescale 1ns/1ps

module gat_top #(
  parameter int DATA_WIDTH         = gat_pkg::DATA_WIDTH,
  parameter int TOTAL_NODES        = gat_pkg::TOTAL_NODES,
  parameter int NUM_FEATURE_IN     = gat_pkg::NUM_FEATURE_IN,
  parameter int NUM_FEATURE_OUT    = gat_pkg::NUM_FEATURE_OUT,
  parameter int H_NUM_SPARSE_DATA  = gat_pkg::H_NUM_SPARSE_DATA,
  parameter int NEW_FEATURE_WIDTH  = gat_pkg::NEW_FEATURE_WIDTH,
  parameter int COL_IDX_WIDTH      = gat_pkg::COL_IDX_WIDTH,
  parameter int H_DATA_WIDTH       = gat_pkg::H_DATA_WIDTH,
  parameter int ROW_LEN_WIDTH      = gat_pkg::ROW_LEN_WIDTH,
  parameter int H_DATA_ADDR_W      = gat_pkg::H_DATA_ADDR_W,
  parameter int NODE_INFO_ADDR_W   = gat_pkg::NODE_INFO_ADDR_W,
  parameter int WEIGHT_ADDR_W      = gat_pkg::WEIGHT_ADDR_W,
  parameter int NEW_FEATURE_ADDR_W = gat_pkg::NEW_FEATURE_ADDR_W
)(
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [H_DATA_WIDTH-1:0]       h_data_din,
  input  logic                          h_data_ena,
  input  logic                          h_data_wea,
  input  logic [H_DATA_ADDR_W-1:0]      h_data_addra,
  input  logic [ROW_LEN_WIDTH-1:0]      node_info_din,
  input  logic                          node_info_ena,
  input  logic                          node_info_wea,
  input  logic [NODE_INFO_ADDR_W-1:0]   node_info_addra,
  input  logic [DATA_WIDTH-1:0]         wgt_din,
  input  logic                          wgt_ena,
  input  logic                          wgt_wea,
  input  logic [WEIGHT_ADDR_W-1:0]      wgt_addra,
  input  logic                          h_done,
  input  logic                          info_done,
  input  logic                          wgt_done,
  output logic                          gat_ready,
  output logic [31:0]                   gat_debug_1,
  output logic [31:0]                   gat_debug_2,
  output logic [31:0]                   gat_debug_3,
  input  logic [NEW_FEATURE_ADDR_W-1:0] feat_addrb,
  output gat_pkg::feat_t                feat_dout
);

  import gat_pkg::*;

  localparam int LANE_W = $clog2(NUM_FEATURE_OUT);

  logic [NODE_INFO_ADDR_W-1:0]   row_idx;
  logic [H_DATA_ADDR_W-1:0]      nz_ptr;
  logic [LANE_W-1:0]             lane;
  logic [H_DATA_WIDTH-1:0]       h_dout;
  logic [ROW_LEN_WIDTH-1:0]      len_dout;
  logic [DATA_WIDTH-1:0]         w_dout;
  logic signed [DATA_WIDTH-1:0]  h_value_q;
  logic [COL_IDX_WIDTH-1:0]      col_q;
  logic [WEIGHT_ADDR_W-1:0]      w_addr;
  logic [NEW_FEATURE_ADDR_W-1:0] f_addr;
  feat_t                         mac_result;
  logic info_rd, nz_rd, feat_we, run_start, row_load, row_inc, nz_inc, lane_inc, lane_clr;
  logic row_last, row_empty, nz_last, lane_last;
  logic info_vld_q, nz_vld_q;
  mac_op_e    mac_op;
  gat_state_e state;

  // ====================================================================
  // Memories
  // ====================================================================
  gat_bram #(.WIDTH(H_DATA_WIDTH), .DEPTH(H_NUM_SPARSE_DATA)) u_h_data_bram (
    .clk(clk), .ena(h_data_ena), .wea(h_data_wea), .addra(h_data_addra),
    .dina(h_data_din), .addrb(nz_ptr), .doutb(h_dout)
  );

  gat_bram #(.WIDTH(ROW_LEN_WIDTH), .DEPTH(TOTAL_NODES)) u_node_info_bram (
    .clk(clk), .ena(node_info_ena), .wea(node_info_wea), .addra(node_info_addra),
    .dina(node_info_din), .addrb(row_idx), .doutb(len_dout)
  );

  gat_bram #(.WIDTH(DATA_WIDTH), .DEPTH(NUM_FEATURE_IN * NUM_FEATURE_OUT)) u_weight_bram (
    .clk(clk), .ena(wgt_ena), .wea(wgt_wea), .addra(wgt_addra),
    .dina(wgt_din), .addrb(w_addr), .doutb(w_dout)
  );

  gat_bram #(.WIDTH(NEW_FEATURE_WIDTH), .DEPTH(TOTAL_NODES * NUM_FEATURE_OUT)) u_feat_bram (
    .clk(clk), .ena(feat_we), .wea(feat_we), .addra(f_addr),
    .dina(mac_result), .addrb(feat_addrb), .doutb(feat_dout)
  );

  // Read data is valid one cycle after the strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      info_vld_q <= 1'b0;
      nz_vld_q   <= 1'b0;
    end else begin
      info_vld_q <= info_rd;
      nz_vld_q   <= nz_rd;
    end
  end

  // Hold the current entry for the whole weight burst
  always_ff @(posedge clk) begin
    if (nz_vld_q) begin
      h_value_q <= h_dout[DATA_WIDTH-1:0];
      col_q     <= h_dout[H_DATA_WIDTH-1:DATA_WIDTH];
    end
  end

  // W(c,j) at c*NUM_FEATURE_OUT+j, WH(r,j) at r*NUM_FEATURE_OUT+j
  assign w_addr = WEIGHT_ADDR_W'(col_q * NUM_FEATURE_OUT + lane);
  assign f_addr = NEW_FEATURE_ADDR_W'(row_idx * NUM_FEATURE_OUT + lane);

  // ====================================================================
  // Control and datapath
  // ====================================================================
  gat_index_counter #(
    .TOTAL_NODES(TOTAL_NODES), .NUM_FEATURE_OUT(NUM_FEATURE_OUT),
    .H_NUM_SPARSE_DATA(H_NUM_SPARSE_DATA), .ROW_LEN_WIDTH(ROW_LEN_WIDTH),
    .H_DATA_ADDR_W(H_DATA_ADDR_W), .NODE_INFO_ADDR_W(NODE_INFO_ADDR_W)
  ) u_index_counter (
    .clk(clk), .arst_n(arst_n), .run_start(run_start), .row_load(row_load),
    .row_len(len_dout), .row_inc(row_inc), .nz_inc(nz_inc), .lane_inc(lane_inc),
    .lane_clr(lane_clr), .row_idx(row_idx), .nz_ptr(nz_ptr), .lane(lane),
    .row_last(row_last), .row_empty(row_empty), .nz_last(nz_last), .lane_last(lane_last),
    .rows_done(gat_debug_1), .nz_done(gat_debug_2)
  );

  gat_ctrl u_ctrl (
    .clk(clk), .arst_n(arst_n), .h_done(h_done), .info_done(info_done),
    .wgt_done(wgt_done), .row_last(row_last), .row_empty(row_empty),
    .nz_last(nz_last), .lane_last(lane_last), .info_rd(info_rd), .nz_rd(nz_rd),
    .feat_we(feat_we), .run_start(run_start), .row_load(row_load), .row_inc(row_inc),
    .nz_inc(nz_inc), .lane_inc(lane_inc), .lane_clr(lane_clr), .mac_op(mac_op),
    .state(state), .gat_ready(gat_ready)
  );

  gat_spmv_mac #(.DATA_WIDTH(DATA_WIDTH), .NUM_FEATURE_OUT(NUM_FEATURE_OUT)) u_mac (
    .clk(clk), .arst_n(arst_n), .mac_op(mac_op), .lane(lane), .h_value(h_value_q),
    .w_value(w_dout), .rd_lane(lane), .result(mac_result)
  );

  assign gat_debug_3 = 32'(state);

  // A row can never hold more entries than H has columns
  a_row_len_range: assert property (@(posedge clk) disable iff (!arst_n)
    info_vld_q |-> (len_dout <= NUM_FEATURE_IN))
    else $error("node_info length %0d exceeds row width", len_dout);

endmodule

//--- gat_top_wrapper.sv
// Host-facing wrapper; turns byte addresses into word addresses and trims 32-bit data to memory widths
`timescale 1ns/1ps

module gat_top_wrapper #(
  parameter int DATA_WIDTH         = gat_pkg::DATA_WIDTH,
  parameter int TOTAL_NODES        = gat_pkg::TOTAL_NODES,
  parameter int NUM_FEATURE_IN     = gat_pkg::NUM_FEATURE_IN,
  parameter int NUM_FEATURE_OUT    = gat_pkg::NUM_FEATURE_OUT,
  parameter int H_NUM_SPARSE_DATA  = gat_pkg::H_NUM_SPARSE_DATA,
  parameter int NEW_FEATURE_WIDTH  = gat_pkg::NEW_FEATURE_WIDTH,
  parameter int COL_IDX_WIDTH      = gat_pkg::COL_IDX_WIDTH,
  parameter int H_DATA_WIDTH       = gat_pkg::H_DATA_WIDTH,
  parameter int ROW_LEN_WIDTH      = gat_pkg::ROW_LEN_WIDTH,
  parameter int H_DATA_ADDR_W      = gat_pkg::H_DATA_ADDR_W,
  parameter int NODE_INFO_ADDR_W   = gat_pkg::NODE_INFO_ADDR_W,
  parameter int WEIGHT_ADDR_W      = gat_pkg::WEIGHT_ADDR_W,
  parameter int NEW_FEATURE_ADDR_W = gat_pkg::NEW_FEATURE_ADDR_W
)(
  input  logic                          clk,
  input  logic                          arst_n,

  // ====================================================================
  // Register bank
  // ====================================================================
  output logic                          gat_ready,
  output logic [31:0]                   gat_debug_1,
  output logic [31:0]                   gat_debug_2,
  output logic [31:0]                   gat_debug_3,
  input  logic                          h_data_bram_load_done,
  input  logic                          h_node_info_bram_load_done,
  input  logic                          wgt_bram_load_done,

  // ====================================================================
  // Memory load and readback ports, byte addressed
  // ====================================================================
  input  logic [31:0]                   h_data_bram_din,
  input  logic                          h_data_bram_ena,
  input  logic                          h_data_bram_wea,
  input  logic [H_DATA_ADDR_W+1:0]      h_data_bram_addra,
  input  logic [31:0]                   h_node_info_bram_din,
  input  logic                          h_node_info_bram_ena,
  input  logic                          h_node_info_bram_wea,
  input  logic [NODE_INFO_ADDR_W+1:0]   h_node_info_bram_addra,
  input  logic [31:0]                   wgt_bram_din,
  input  logic                          wgt_bram_ena,
  input  logic                          wgt_bram_wea,
  input  logic [WEIGHT_ADDR_W+1:0]      wgt_bram_addra,
  input  logic [NEW_FEATURE_ADDR_W+1:0] feat_bram_addrb,
  output gat_pkg::feat_t                feat_bram_dout
);

  gat_top #(
    .DATA_WIDTH(DATA_WIDTH), .TOTAL_NODES(TOTAL_NODES),
    .NUM_FEATURE_IN(NUM_FEATURE_IN), .NUM_FEATURE_OUT(NUM_FEATURE_OUT),
    .H_NUM_SPARSE_DATA(H_NUM_SPARSE_DATA), .NEW_FEATURE_WIDTH(NEW_FEATURE_WIDTH),
    .COL_IDX_WIDTH(COL_IDX_WIDTH), .H_DATA_WIDTH(H_DATA_WIDTH),
    .ROW_LEN_WIDTH(ROW_LEN_WIDTH), .H_DATA_ADDR_W(H_DATA_ADDR_W),
    .NODE_INFO_ADDR_W(NODE_INFO_ADDR_W), .WEIGHT_ADDR_W(WEIGHT_ADDR_W),
    .NEW_FEATURE_ADDR_W(NEW_FEATURE_ADDR_W)
  ) u_gat_top (
    .clk             (clk),
    .arst_n          (arst_n),
    // Word address is the byte address without its low two bits
    .h_data_din      (h_data_bram_din[H_DATA_WIDTH-1:0]),
    .h_data_ena      (h_data_bram_ena),
    .h_data_wea      (h_data_bram_wea),
    .h_data_addra    (h_data_bram_addra[H_DATA_ADDR_W+1:2]),
    .node_info_din   (h_node_info_bram_din[ROW_LEN_WIDTH-1:0]),
    .node_info_ena   (h_node_info_bram_ena),
    .node_info_wea   (h_node_info_bram_wea),
    .node_info_addra (h_node_info_bram_addra[NODE_INFO_ADDR_W+1:2]),
    .wgt_din         (wgt_bram_din[DATA_WIDTH-1:0]),
    .wgt_ena         (wgt_bram_ena),
    .wgt_wea         (wgt_bram_wea),
    .wgt_addra       (wgt_bram_addra[WEIGHT_ADDR_W+1:2]),
    .h_done          (h_data_bram_load_done),
    .info_done       (h_node_info_bram_load_done),
    .wgt_done        (wgt_bram_load_done),
    .gat_ready       (gat_ready),
    .gat_debug_1     (gat_debug_1),
    .gat_debug_2     (gat_debug_2),
    .gat_debug_3     (gat_debug_3),
    .feat_addrb      (feat_bram_addrb[NEW_FEATURE_ADDR_W+1:2]),
    .feat_dout       (feat_bram_dout)
  );

endmodule

//--- tb_gat_top_wrapper.sv
// Self-checking testbench for gat_top_wrapper; runs a table of sparse H and dense W cases
`timescale 1ns/1ps

module tb_gat_top_wrapper;
  import gat_pkg::*;

  typedef enum {DENS_EMPTY, DENS_SINGLE, DENS_FULL, DENS_RANDOM} density_e;
  typedef enum {VAL_SMALL, VAL_EXTREME} vmode_e;
  typedef enum {SIGN_POS, SIGN_NEG, SIGN_MIXED} sign_e;

  localparam int NUM_TESTS   = 8;
  localparam int SEED        = 66129;
  localparam int HA_W        = H_DATA_ADDR_W + 2;
  localparam int NA_W        = NODE_INFO_ADDR_W + 2;
  localparam int WA_W        = WEIGHT_ADDR_W + 2;
  localparam int FA_W        = NEW_FEATURE_ADDR_W + 2;
  localparam int VAL_MASK    = (1 << DATA_WIDTH) - 1;
  // Worst row is a full one, plus loading, readback and handshake margin
  localparam int ROW_WORST   = 3 + NUM_FEATURE_IN * (NUM_FEATURE_OUT + 3) + NUM_FEATURE_OUT;
  localparam int LOAD_CYC    = H_NUM_SPARSE_DATA + TOTAL_NODES + NUM_FEATURE_IN * NUM_FEATURE_OUT;
  localparam int READ_CYC    = 2 * TOTAL_NODES * NUM_FEATURE_OUT;
  localparam int TEST_CYC    = ROW_WORST * TOTAL_NODES + LOAD_CYC + READ_CYC + 16;
  localparam int TIMEOUT_CYC = 2 * (NUM_TESTS * TEST_CYC + 16);

  logic clk, arst_n;
  logic gat_ready;
  logic [31:0] gat_debug_1, gat_debug_2, gat_debug_3;
  logic h_done, info_done, wgt_done;
  logic [31:0] h_din, info_din, wgt_din;
  logic h_ena, h_wea, info_ena, info_wea, wgt_ena, wgt_wea;
  logic [HA_W-1:0] h_addr;
  logic [NA_W-1:0] info_addr;
  logic [WA_W-1:0] wgt_addr;
  logic [FA_W-1:0] feat_addr;
  feat_t           feat_dout;

  // Reference data for the current table row
  int    h_val [H_NUM_SPARSE_DATA];
  int    h_col [H_NUM_SPARSE_DATA];
  int    row_len [TOTAL_NODES];
  int    w_mat [NUM_FEATURE_IN][NUM_FEATURE_OUT];
  feat_t exp_feat [TOTAL_NODES][NUM_FEATURE_OUT];
  int    nnz_total;
  int    check_cnt = 0;
  int    err_cnt = 0;
  int    cycle_cnt = 0;

  // ====================================================================
  // Test table
  // ====================================================================
  string    test_name [NUM_TESTS] = '{"empty_rows", "single_entry", "full_rows",
    "random_small", "extreme_pos_w", "extreme_neg_w", "random_extreme", "single_neg_w"};
  density_e test_dens [NUM_TESTS] = '{DENS_EMPTY, DENS_SINGLE, DENS_FULL, DENS_RANDOM,
    DENS_FULL, DENS_FULL, DENS_RANDOM, DENS_SINGLE};
  vmode_e   test_vmode [NUM_TESTS] = '{VAL_SMALL, VAL_SMALL, VAL_SMALL, VAL_SMALL,
    VAL_EXTREME, VAL_EXTREME, VAL_EXTREME, VAL_SMALL};
  sign_e    test_sign [NUM_TESTS] = '{SIGN_MIXED, SIGN_POS, SIGN_MIXED, SIGN_MIXED,
    SIGN_POS, SIGN_NEG, SIGN_MIXED, SIGN_NEG};

  gat_top_wrapper gat_top_wrapper_i (
    .clk(clk), .arst_n(arst_n), .gat_ready(gat_ready),
    .gat_debug_1(gat_debug_1), .gat_debug_2(gat_debug_2), .gat_debug_3(gat_debug_3),
    .h_data_bram_load_done(h_done), .h_node_info_bram_load_done(info_done),
    .wgt_bram_load_done(wgt_done),
    .h_data_bram_din(h_din), .h_data_bram_ena(h_ena), .h_data_bram_wea(h_wea),
    .h_data_bram_addra(h_addr),
    .h_node_info_bram_din(info_din), .h_node_info_bram_ena(info_ena),
    .h_node_info_bram_wea(info_wea), .h_node_info_bram_addra(info_addr),
    .wgt_bram_din(wgt_din), .wgt_bram_ena(wgt_ena), .wgt_bram_wea(wgt_wea),
    .wgt_bram_addra(wgt_addr),
    .feat_bram_addrb(feat_addr), .feat_bram_dout(feat_dout)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Watchdog on total run length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, the DUT never finished its run", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic check_feat(input string sig, input feat_t got, input feat_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED %s got %h expected %h", sig, got, exp);
    end
  endtask

  task automatic check_count(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED %s got %h expected %h", sig, got, exp);
    end
  endtask

  task automatic check_state(input string sig, input gat_state_e got, input gat_state_e exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED %s got %h expected %h", sig, got, exp);
    end
  endtask

  task automatic check_bit(input string sig, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED %s got %h expected %h", sig, got, exp);
    end
  endtask

  // ====================================================================
  // Stimulus and reference model
  // ====================================================================
  function automatic int pick_value(input vmode_e vm, input sign_e sm);
    int v;
    if (vm == VAL_EXTREME) begin
      if (sm == SIGN_POS) v = 127;
      else if (sm == SIGN_NEG) v = -128;
      else v = ($urandom_range(0, 1) == 0) ? -128 : 127;
    end else begin
      if (sm == SIGN_POS) v = int'($urandom_range(1, 9));
      else if (sm == SIGN_NEG) v = -int'($urandom_range(1, 9));
      else v = int'($urandom_range(0, 17)) - 9;
    end
    return v;
  endfunction

  task automatic gen_data(input density_e dm, input vmode_e vm, input sign_e sm);
    int n;
    int k;
    for (int c = 0; c < NUM_FEATURE_IN; c++) begin
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        w_mat[c][j] = pick_value(vm, sm);
      end
    end
    nnz_total = 0;
    for (int r = 0; r < TOTAL_NODES; r++) begin
      case (dm)
        DENS_EMPTY:  n = 0;
        DENS_SINGLE: n = 1;
        // Full rows until the nonzero memory runs out, then empty rows
        DENS_FULL:   n = (nnz_total + NUM_FEATURE_IN <= H_NUM_SPARSE_DATA) ? NUM_FEATURE_IN : 0;
        default:     n = int'($urandom_range(0, H_NUM_SPARSE_DATA / TOTAL_NODES));
      endcase
      row_len[r] = n;
      for (int e = 0; e < n; e++) begin
        k = nnz_total + e;
        h_col[k] = (dm == DENS_FULL) ? e : int'($urandom_range(0, NUM_FEATURE_IN - 1));
        h_val[k] = pick_value(vm, SIGN_MIXED);
      end
      nnz_total += n;
    end
  endtask

  task automatic compute_expected();
    int k;
    int sum;
    k = 0;
    for (int r = 0; r < TOTAL_NODES; r++) begin
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        sum = 0;
        for (int e = 0; e < row_len[r]; e++) begin
          sum += h_val[k + e] * w_mat[h_col[k + e]][j];
        end
        exp_feat[r][j] = feat_t'(sum);
      end
      k += row_len[r];
    end
  endtask

  task automatic load_memories();
    for (int k = 0; k < nnz_total; k++) begin
      @(negedge clk);
      {h_ena, h_wea} = 2'b11;
      h_addr = HA_W'(k * 4);
      h_din  = 32'((h_col[k] << DATA_WIDTH) | (h_val[k] & VAL_MASK));
    end
    for (int r = 0; r < TOTAL_NODES; r++) begin
      @(negedge clk);
      {h_ena, h_wea} = 2'b00;
      {info_ena, info_wea} = 2'b11;
      info_addr = NA_W'(r * 4);
      info_din  = 32'(row_len[r]);
    end
    for (int c = 0; c < NUM_FEATURE_IN; c++) begin
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        @(negedge clk);
        {info_ena, info_wea} = 2'b00;
        {wgt_ena, wgt_wea} = 2'b11;
        wgt_addr = WA_W'((c * NUM_FEATURE_OUT + j) * 4);
        wgt_din  = 32'(w_mat[c][j] & VAL_MASK);
      end
    end
    @(negedge clk);
    {wgt_ena, wgt_wea} = 2'b00;
  endtask

  task automatic read_features();
    for (int r = 0; r < TOTAL_NODES; r++) begin
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        @(negedge clk);
        feat_addr = FA_W'((r * NUM_FEATURE_OUT + j) * 4);
        @(negedge clk);
        check_feat($sformatf("feat_bram_dout row %0d lane %0d", r, j), feat_dout,
                   exp_feat[r][j]);
      end
    end
  endtask

  task automatic run_test(input int idx);
    int chk0;
    int err0;
    chk0 = check_cnt;
    err0 = err_cnt;
    check_bit("gat_ready", gat_ready, 1'b0);
    check_state("gat_debug_3", gat_state_e'(gat_debug_3[3:0]), IDLE);
    gen_data(test_dens[idx], test_vmode[idx], test_sign[idx]);
    compute_expected();
    load_memories();
    {h_done, info_done, wgt_done} = 3'b111;
    // Watchdog bounds this wait
    while (gat_ready !== 1'b1) begin
      @(negedge clk);
    end
    check_count("gat_debug_1", gat_debug_1, 32'(TOTAL_NODES));
    check_count("gat_debug_2", gat_debug_2, 32'(nnz_total));
    check_state("gat_debug_3", gat_state_e'(gat_debug_3[3:0]), DONE);
    check_count("gat_debug_3 upper bits", 32'(gat_debug_3[31:4]), 32'd0);
    read_features();
    check_bit("gat_ready", gat_ready, 1'b1);
    // One falling level ends the run on the next clock
    wgt_done = 1'b0;
    @(negedge clk);
    check_bit("gat_ready", gat_ready, 1'b0);
    check_state("gat_debug_3", gat_state_e'(gat_debug_3[3:0]), IDLE);
    {h_done, info_done} = 2'b00;
    @(negedge clk);
    $display("%s: %s (%0d checks, %0d errors)", test_name[idx],
             (err_cnt == err0) ? "ok" : "failed", check_cnt - chk0, err_cnt - err0);
  endtask

  initial begin
    arst_n = 1'b0;
    {h_done, info_done, wgt_done} = 3'b000;
    {h_ena, h_wea, info_ena, info_wea, wgt_ena, wgt_wea} = 6'b0;
    h_din = '0;
    info_din = '0;
    wgt_din = '0;
    h_addr = '0;
    info_addr = '0;
    wgt_addr = '0;
    feat_addr = '0;
    void'($urandom(SEED));
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- gat_top_wrapper.f
gat_pkg.sv
gat_bram.sv
gat_index_counter.sv
gat_ctrl.sv
gat_spmv_mac.sv
gat_top.sv
gat_top_wrapper.sv
tb_gat_top_wrapper.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_gat_top_wrapper
FILELIST  ?= gat_top_wrapper.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
